// ==== verilog/lite_demux_pkg.sv ====
// lite_demux package
// sizes, port count, select fifo depth and the axi4-lite channel structs
package lite_demux_pkg;

  // ------------------------------------------------
  // sizes
  // ------------------------------------------------
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned STRB_W    = DATA_W / 8;
  localparam int unsigned NUM_PORTS = 4;                  // downstream ports, 2 or more
  localparam int unsigned SEL_W     = $clog2(NUM_PORTS);
  localparam int unsigned MAX_TRANS = 4;                  // open transactions per select fifo

  typedef logic [SEL_W-1:0] sel_t;        // downstream port index
  typedef logic [1:0]       resp_code_t;  // okay / exokay / slverr / decerr

  // ------------------------------------------------
  // channel payloads
  // ------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } aw_chan_t;  // 35 bits

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } ar_chan_t;  // same layout as aw

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    resp_code_t resp;
  } b_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_code_t        resp;
  } r_chan_t;

  // ------------------------------------------------
  // bundles, master side and slave side
  // ------------------------------------------------
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } lite_resp_t;

endpackage

// ==== verilog/select_fifo.sv ====
// select fifo
// circular queue of port selects, no fall-through, full and empty flags
`timescale 1ns/1ps

module select_fifo #(
  parameter int unsigned DEPTH = lite_demux_pkg::MAX_TRANS
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 push_i,
  input  lite_demux_pkg::sel_t sel_i,
  input  logic                 pop_i,
  output lite_demux_pkg::sel_t sel_o,
  output logic                 full_o,
  output logic                 empty_o
);
  import lite_demux_pkg::*;

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;  // holds 0..DEPTH

  sel_t mem_q [DEPTH];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t cnt_q;

  // wrap at DEPTH, depth need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign sel_o   = mem_q[rd_ptr_q];       // head, valid only when not empty
  assign full_o  = (cnt_q == cnt_t'(DEPTH));
  assign empty_o = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push_i && !pop_i)      cnt_q <= cnt_q + 1'b1;
      else if (pop_i && !push_i) cnt_q <= cnt_q - 1'b1;  // simultaneous push/pop keeps count
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= sel_i;
  end

  // callers gate push on full and pop on empty
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("select_fifo: push while full");
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("select_fifo: pop while empty");

endmodule

// ==== verilog/aw_dispatch.sv ====
// aw dispatch
// steers aw to the selected port, pushes the select once per request
`timescale 1ns/1ps

module aw_dispatch (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 aw_valid_i,
  input  lite_demux_pkg::sel_t                 aw_sel_i,
  output logic                                 aw_ready_o,
  output logic [lite_demux_pkg::NUM_PORTS-1:0] port_aw_valid_o,
  input  logic [lite_demux_pkg::NUM_PORTS-1:0] port_aw_ready_i,
  input  logic                                 fifo_full_i,
  output logic                                 fifo_push_o
);
  import lite_demux_pkg::*;

  logic lock_q;  // select already queued, port has not taken the aw yet
  logic lock_d;

  always_comb begin
    lock_d          = lock_q;
    aw_ready_o      = 1'b0;
    port_aw_valid_o = '0;
    fifo_push_o     = 1'b0;
    if (lock_q) begin
      // held request, no further push
      port_aw_valid_o[aw_sel_i] = 1'b1;
      if (port_aw_ready_i[aw_sel_i]) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;  // back to idle
      end
    end else if (aw_valid_i && !fifo_full_i) begin
      // first presentation, queue select for the w beat
      fifo_push_o               = 1'b1;
      port_aw_valid_o[aw_sel_i] = 1'b1;
      if (port_aw_ready_i[aw_sel_i]) begin
        aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;      // port stalls, hold valid
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) lock_q <= 1'b0;
    else          lock_q <= lock_d;
  end

  // ------------------------------------------------
  // upstream rules
  // ------------------------------------------------
  a_aw_sel_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      aw_valid_i |-> (aw_sel_i < NUM_PORTS))
    else $error("aw_dispatch: aw_sel_i %0h out of range", aw_sel_i);

  // the lock relies on the master keeping the request while stalled
  a_aw_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (aw_valid_i && !aw_ready_o) |=> (aw_valid_i && $stable(aw_sel_i)))
    else $error("aw_dispatch: aw valid or select changed while stalled");

endmodule

// ==== verilog/write_return.sv ====
// write return path
// steers w beats by the queued aw select, queues selects for b and merges b upstream
`timescale 1ns/1ps

module write_return (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // upstream w
  input  logic                                            w_valid_i,
  output logic                                            w_ready_o,
  // head of the w select fifo
  input  lite_demux_pkg::sel_t                            w_sel_i,
  input  logic                                            w_empty_i,
  output logic                                            w_pop_o,
  // downstream w
  output logic [lite_demux_pkg::NUM_PORTS-1:0]            port_w_valid_o,
  input  logic [lite_demux_pkg::NUM_PORTS-1:0]            port_w_ready_i,
  // downstream b
  input  lite_demux_pkg::b_chan_t [lite_demux_pkg::NUM_PORTS-1:0] port_b_i,
  input  logic [lite_demux_pkg::NUM_PORTS-1:0]            port_b_valid_i,
  output logic [lite_demux_pkg::NUM_PORTS-1:0]            port_b_ready_o,
  // upstream b
  output lite_demux_pkg::b_chan_t                         b_o,
  output logic                                            b_valid_o,
  input  logic                                            b_ready_i
);
  import lite_demux_pkg::*;

  sel_t b_sel;    // port owing the oldest b
  logic b_full;
  logic b_empty;
  logic b_pop;
  logic w_go;     // w target known and room to track its b

  assign w_go = !w_empty_i && !b_full;

  // ------------------------------------------------
  // w steering
  // ------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      port_w_valid_o[i] = w_go && w_valid_i && (w_sel_i == sel_t'(i));
      port_b_ready_o[i] = !b_empty && b_ready_i && (b_sel == sel_t'(i));  // head port only
    end
  end

  assign w_ready_o = w_go && port_w_ready_i[w_sel_i];
  assign w_pop_o   = w_valid_i && w_ready_o;  // beat done, also pushes the b select

  select_fifo #(
    .DEPTH   ( MAX_TRANS )
  ) i_b_fifo (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .push_i  ( w_pop_o   ),
    .sel_i   ( w_sel_i   ),
    .pop_i   ( b_pop     ),
    .sel_o   ( b_sel     ),
    .full_o  ( b_full    ),
    .empty_o ( b_empty   )
  );

  // ------------------------------------------------
  // b merge
  // ------------------------------------------------
  assign b_o       = b_empty ? '0 : port_b_i[b_sel];  // zero when nothing pending
  assign b_valid_o = !b_empty && port_b_valid_i[b_sel];
  assign b_pop     = b_valid_o && b_ready_i;

endmodule

// ==== verilog/read_route.sv ====
// read route
// steers ar to the selected port, queues the select, returns r from the head port
`timescale 1ns/1ps

module read_route (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // upstream ar
  input  logic                                            ar_valid_i,
  input  lite_demux_pkg::sel_t                            ar_sel_i,
  output logic                                            ar_ready_o,
  // downstream ar
  output logic [lite_demux_pkg::NUM_PORTS-1:0]            port_ar_valid_o,
  input  logic [lite_demux_pkg::NUM_PORTS-1:0]            port_ar_ready_i,
  // downstream r
  input  lite_demux_pkg::r_chan_t [lite_demux_pkg::NUM_PORTS-1:0] port_r_i,
  input  logic [lite_demux_pkg::NUM_PORTS-1:0]            port_r_valid_i,
  output logic [lite_demux_pkg::NUM_PORTS-1:0]            port_r_ready_o,
  // upstream r
  output lite_demux_pkg::r_chan_t                         r_o,
  output logic                                            r_valid_o,
  input  logic                                            r_ready_i
);
  import lite_demux_pkg::*;

  sel_t r_sel;     // port owing the oldest r
  logic r_full;
  logic r_empty;
  logic r_push;
  logic r_pop;

  // ------------------------------------------------
  // ar steering
  // ------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      // no valid while the queue cannot take the select
      port_ar_valid_o[i] = !r_full && ar_valid_i && (ar_sel_i == sel_t'(i));
      port_r_ready_o[i]  = !r_empty && r_ready_i && (r_sel == sel_t'(i));
    end
  end

  assign ar_ready_o = !r_full && port_ar_ready_i[ar_sel_i];
  assign r_push     = ar_valid_i && ar_ready_o;

  select_fifo #(
    .DEPTH   ( MAX_TRANS )
  ) i_r_fifo (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .push_i  ( r_push    ),
    .sel_i   ( ar_sel_i  ),
    .pop_i   ( r_pop     ),
    .sel_o   ( r_sel     ),
    .full_o  ( r_full    ),
    .empty_o ( r_empty   )
  );

  // ------------------------------------------------
  // r merge
  // ------------------------------------------------
  assign r_o       = r_empty ? '0 : port_r_i[r_sel];
  assign r_valid_o = !r_empty && port_r_valid_i[r_sel];
  assign r_pop     = r_valid_o && r_ready_i;

  // ------------------------------------------------
  // upstream rules
  // ------------------------------------------------
  a_ar_sel_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_i |-> (ar_sel_i < NUM_PORTS))
    else $error("read_route: ar_sel_i %0h out of range", ar_sel_i);

  // a stalled ar must not retarget, or the queued order breaks
  a_ar_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ar_valid_i && !ar_ready_o) |=> (ar_valid_i && $stable(ar_sel_i)))
    else $error("read_route: ar valid or select changed while stalled");

endmodule

// ==== verilog/lite_demux.sv ====
// axi4-lite demux top
// one upstream port to NUM_PORTS downstream ports, routed by the aw/ar selects
`timescale 1ns/1ps

module lite_demux (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  // upstream, master connects here
  input  lite_demux_pkg::lite_req_t                             slv_req_i,
  input  lite_demux_pkg::sel_t                                  slv_aw_sel_i,
  input  lite_demux_pkg::sel_t                                  slv_ar_sel_i,
  output lite_demux_pkg::lite_resp_t                            slv_resp_o,
  // downstream, slaves connect here
  output lite_demux_pkg::lite_req_t  [lite_demux_pkg::NUM_PORTS-1:0] mst_req_o,
  input  lite_demux_pkg::lite_resp_t [lite_demux_pkg::NUM_PORTS-1:0] mst_resp_i
);
  import lite_demux_pkg::*;

  // per-port control vectors
  logic    [NUM_PORTS-1:0] aw_valid, aw_ready;
  logic    [NUM_PORTS-1:0] w_valid, w_ready;
  logic    [NUM_PORTS-1:0] b_valid, b_ready;
  logic    [NUM_PORTS-1:0] ar_valid, ar_ready;
  logic    [NUM_PORTS-1:0] r_valid, r_ready;
  b_chan_t [NUM_PORTS-1:0] port_b;
  r_chan_t [NUM_PORTS-1:0] port_r;

  // w select fifo
  logic w_push;
  logic w_pop;
  logic w_full;
  logic w_empty;
  sel_t w_sel;

  // ------------------------------------------------
  // unpack bundles, payloads go to every port
  // ------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign mst_req_o[i].aw       = slv_req_i.aw;
    assign mst_req_o[i].aw_valid = aw_valid[i];
    assign mst_req_o[i].w        = slv_req_i.w;
    assign mst_req_o[i].w_valid  = w_valid[i];
    assign mst_req_o[i].b_ready  = b_ready[i];
    assign mst_req_o[i].ar       = slv_req_i.ar;
    assign mst_req_o[i].ar_valid = ar_valid[i];
    assign mst_req_o[i].r_ready  = r_ready[i];

    assign aw_ready[i] = mst_resp_i[i].aw_ready;
    assign w_ready[i]  = mst_resp_i[i].w_ready;
    assign port_b[i]   = mst_resp_i[i].b;
    assign b_valid[i]  = mst_resp_i[i].b_valid;
    assign ar_ready[i] = mst_resp_i[i].ar_ready;
    assign port_r[i]   = mst_resp_i[i].r;
    assign r_valid[i]  = mst_resp_i[i].r_valid;
  end

  // ------------------------------------------------
  // write side
  // ------------------------------------------------
  aw_dispatch i_aw_dispatch (
    .clk_i           ( clk_i               ),
    .rst_n_i         ( rst_n_i             ),
    .aw_valid_i      ( slv_req_i.aw_valid  ),
    .aw_sel_i        ( slv_aw_sel_i        ),
    .aw_ready_o      ( slv_resp_o.aw_ready ),
    .port_aw_valid_o ( aw_valid            ),
    .port_aw_ready_i ( aw_ready            ),
    .fifo_full_i     ( w_full              ),
    .fifo_push_o     ( w_push              )
  );

  select_fifo #(
    .DEPTH   ( MAX_TRANS    )
  ) i_w_fifo (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .push_i  ( w_push       ),
    .sel_i   ( slv_aw_sel_i ),  // order of accepted aw
    .pop_i   ( w_pop        ),
    .sel_o   ( w_sel        ),
    .full_o  ( w_full       ),
    .empty_o ( w_empty      )
  );

  write_return i_write_return (
    .clk_i          ( clk_i              ),
    .rst_n_i        ( rst_n_i            ),
    .w_valid_i      ( slv_req_i.w_valid  ),
    .w_ready_o      ( slv_resp_o.w_ready ),
    .w_sel_i        ( w_sel              ),
    .w_empty_i      ( w_empty            ),
    .w_pop_o        ( w_pop              ),
    .port_w_valid_o ( w_valid            ),
    .port_w_ready_i ( w_ready            ),
    .port_b_i       ( port_b             ),
    .port_b_valid_i ( b_valid            ),
    .port_b_ready_o ( b_ready            ),
    .b_o            ( slv_resp_o.b       ),
    .b_valid_o      ( slv_resp_o.b_valid ),
    .b_ready_i      ( slv_req_i.b_ready  )
  );

  // ------------------------------------------------
  // read side
  // ------------------------------------------------
  read_route i_read_route (
    .clk_i           ( clk_i               ),
    .rst_n_i         ( rst_n_i             ),
    .ar_valid_i      ( slv_req_i.ar_valid  ),
    .ar_sel_i        ( slv_ar_sel_i        ),
    .ar_ready_o      ( slv_resp_o.ar_ready ),
    .port_ar_valid_o ( ar_valid            ),
    .port_ar_ready_i ( ar_ready            ),
    .port_r_i        ( port_r              ),
    .port_r_valid_i  ( r_valid             ),
    .port_r_ready_o  ( r_ready             ),
    .r_o             ( slv_resp_o.r        ),
    .r_valid_o       ( slv_resp_o.r_valid  ),
    .r_ready_i       ( slv_req_i.r_ready   )
  );

endmodule

// ==== bench/lite_demux_tb.sv ====
// lite_demux testbench
// random upstream traffic, random-stall slaves on every port, in-order scoreboard
`timescale 1ns/1ps

module lite_demux_tb;
  import lite_demux_pkg::*;

  localparam int NUM_WR   = 200;
  localparam int NUM_RD   = 200;
  localparam int CLK_NS   = 4;
  localparam int WATCH_NS = (NUM_WR + NUM_RD) * 40 * CLK_NS;  // 40 cycles per transaction

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  lite_req_t                  req;          // upstream master
  sel_t                       aw_sel;
  sel_t                       ar_sel;
  lite_resp_t                 slv_resp;
  lite_req_t  [NUM_PORTS-1:0] mst_req;
  lite_resp_t [NUM_PORTS-1:0] mst_resp;     // slave models

  integer seed = 32'h062949df;
  int     errors;
  int     checks;
  int     aw_issued, w_issued, ar_issued, b_done, r_done;

  // expected order, one entry per issued aw and per accepted ar
  sel_t        w_exp_q[$];
  sel_t        b_exp_q[$];
  sel_t        r_sel_q[$];
  logic [31:0] r_addr_q[$];

  // slave state per port
  int          b_cnt [NUM_PORTS];   // b responses owed
  int          r_cnt [NUM_PORTS];
  logic [31:0] r_mem [NUM_PORTS][8];
  logic [2:0]  r_wp  [NUM_PORTS];
  logic [2:0]  r_rp  [NUM_PORTS];

  always #(CLK_NS / 2) clk_i = ~clk_i;

  lite_demux uut (
    .clk_i        ( clk_i    ),
    .rst_n_i      ( rst_n_i  ),
    .slv_req_i    ( req      ),
    .slv_aw_sel_i ( aw_sel   ),
    .slv_ar_sel_i ( ar_sel   ),
    .slv_resp_o   ( slv_resp ),
    .mst_req_o    ( mst_req  ),
    .mst_resp_i   ( mst_resp )
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic coin(int pct);
    return (rand_word() % 100) < pct;
  endfunction

  task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("mismatch %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic check_true(logic ok, string what);
    checks++;
    assert (ok)
    else begin
      errors++;
      $display("error at %0t ns: %s", $time, what);
    end
  endtask

  // --------------------------------------------------
  // monitor, scoreboard, master and slave drivers
  // --------------------------------------------------
  always @(posedge clk_i) begin
    int   aw_hot, ar_hot, aw_pf, w_pf, ar_pf;
    sel_t head;
    sel_t aw_next;
    if (rst_n_i) begin
      aw_hot = 0;
      ar_hot = 0;
      aw_pf  = 0;
      w_pf   = 0;
      ar_pf  = 0;
      if (slv_resp.b_valid && req.b_ready) begin
        if (b_exp_q.size() == 0) check_true(1'b0, "b response with no write outstanding");
        else check_eq("slv_resp_o.b.resp", slv_resp.b.resp, b_exp_q.pop_front());
        b_done++;
      end
      if (slv_resp.r_valid && req.r_ready) begin
        if (r_sel_q.size() == 0) begin
          check_true(1'b0, "r response with no read outstanding");
        end else begin
          head = r_sel_q.pop_front();
          check_eq("slv_resp_o.r.data", slv_resp.r.data, r_addr_q.pop_front() ^ head);
          check_eq("slv_resp_o.r.resp", slv_resp.r.resp, head);
        end
        r_done++;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (mst_req[p].aw_valid) begin
          aw_hot++;
          check_true(req.aw_valid && aw_sel == p, "aw_valid at a port that was not selected");
          if (mst_resp[p].aw_ready) begin
            aw_pf++;
            check_eq("mst_req_o.aw", mst_req[p].aw, req.aw);  // address and prot
          end
        end
        if (mst_req[p].w_valid && mst_resp[p].w_ready) begin
          w_pf++;
          if (w_exp_q.size() == 0) check_true(1'b0, "w beat at a port with no aw outstanding");
          else check_eq("w beat port index", p, w_exp_q.pop_front());
          check_eq("mst_req_o.w", mst_req[p].w, req.w);  // data and strobe unchanged
          b_cnt[p]++;
        end
        if (mst_req[p].b_ready && mst_resp[p].b_valid) b_cnt[p]--;
        if (mst_req[p].ar_valid) begin
          ar_hot++;
          check_true(req.ar_valid && ar_sel == p, "ar_valid at a port that was not selected");
          if (mst_resp[p].ar_ready) begin
            ar_pf++;
            check_eq("mst_req_o.ar", mst_req[p].ar, req.ar);  // address and prot
            r_mem[p][r_wp[p]] = mst_req[p].ar.addr ^ p;  // slave read data rule
            r_wp[p]++;
            r_cnt[p]++;
          end
        end
        if (mst_req[p].r_ready && mst_resp[p].r_valid) begin
          r_rp[p]++;
          r_cnt[p]--;
        end
        // slave responses, held while stalled
        mst_resp[p].aw_ready <= coin(35);
        mst_resp[p].w_ready  <= coin(35);
        mst_resp[p].ar_ready <= coin(35);
        if (!mst_resp[p].b_valid || mst_req[p].b_ready) begin
          mst_resp[p].b_valid <= (b_cnt[p] > 0) && coin(50);
          mst_resp[p].b.resp  <= resp_code_t'(p);
        end
        if (!mst_resp[p].r_valid || mst_req[p].r_ready) begin
          mst_resp[p].r_valid <= (r_cnt[p] > 0) && coin(50);
          mst_resp[p].r.data  <= r_mem[p][r_rp[p]];
          mst_resp[p].r.resp  <= resp_code_t'(p);
        end
      end
      check_true(aw_hot <= 1, "aw_valid high at more than one port");
      check_true(ar_hot <= 1, "ar_valid high at more than one port");
      check_eq("aw port transfers", aw_pf, req.aw_valid && slv_resp.aw_ready);
      check_eq("w port transfers", w_pf, req.w_valid && slv_resp.w_ready);
      check_eq("ar port transfers", ar_pf, req.ar_valid && slv_resp.ar_ready);
      if (req.ar_valid && slv_resp.ar_ready) begin
        r_sel_q.push_back(ar_sel);
        r_addr_q.push_back(req.ar.addr);
      end
      // upstream master, each valid held until its transfer
      if (!req.aw_valid || slv_resp.aw_ready) begin
        req.aw_valid <= 1'b0;
        if (aw_issued < NUM_WR && coin(50)) begin
          aw_next      = sel_t'(rand_word());
          req.aw_valid <= 1'b1;
          req.aw.addr  <= rand_word();
          req.aw.prot  <= 3'(rand_word());
          aw_sel       <= aw_next;
          // demux queues the select on first presentation, w may pass a stalled aw
          w_exp_q.push_back(aw_next);
          b_exp_q.push_back(aw_next);
          aw_issued++;
        end
      end
      if (!req.w_valid || slv_resp.w_ready) begin
        req.w_valid <= 1'b0;
        if (w_issued < NUM_WR && coin(50)) begin
          req.w_valid <= 1'b1;
          req.w.data  <= rand_word();
          req.w.strb  <= 4'(rand_word());
          w_issued++;
        end
      end
      if (!req.ar_valid || slv_resp.ar_ready) begin
        req.ar_valid <= 1'b0;
        if (ar_issued < NUM_RD && coin(50)) begin
          req.ar_valid <= 1'b1;
          req.ar.addr  <= rand_word();
          req.ar.prot  <= 3'(rand_word());
          ar_sel       <= sel_t'(rand_word());
          ar_issued++;
        end
      end
      req.b_ready <= coin(60);
      req.r_ready <= coin(60);
    end
  end

  // --------------------------------------------------
  // reset, end of run
  // --------------------------------------------------
  initial begin
    rst_n_i  = 1'b0;
    req      = '0;
    aw_sel   = '0;
    ar_sel   = '0;
    mst_resp = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      r_wp[p] = '0;  // slave read queues start empty
      r_rp[p] = '0;
    end
    repeat (2) @(posedge clk_i);
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_eq("mst_req_o.aw_valid", mst_req[p].aw_valid, 1'b0);
      check_eq("mst_req_o.w_valid", mst_req[p].w_valid, 1'b0);
      check_eq("mst_req_o.ar_valid", mst_req[p].ar_valid, 1'b0);
    end
    check_eq("slv_resp_o.b_valid", slv_resp.b_valid, 1'b0);
    check_eq("slv_resp_o.r_valid", slv_resp.r_valid, 1'b0);
    rst_n_i <= 1'b1;
    wait (b_done >= NUM_WR && r_done >= NUM_RD);
    repeat (20) @(posedge clk_i);  // catch late duplicates
    @(negedge clk_i);
    check_eq("writes completed", b_done, aw_issued);
    check_eq("reads completed", r_done, ar_issued);
    check_true(w_exp_q.size() == 0 && b_exp_q.size() == 0, "write selects left over");
    check_true(r_sel_q.size() == 0, "read selects left over");
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_true(b_cnt[p] == 0 && r_cnt[p] == 0, "slave still owes a response");
    end
    $display("checks %0d, errors %0d, writes %0d/%0d, reads %0d/%0d",
             checks, errors, b_done, aw_issued, r_done, ar_issued);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCH_NS);
    $display("timeout after %0d ns, errors %0d, writes %0d/%0d, reads %0d/%0d",
             WATCH_NS, errors, b_done, NUM_WR, r_done, NUM_RD);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== lite_demux.f ====
verilog/lite_demux_pkg.sv
verilog/select_fifo.sv
verilog/aw_dispatch.sv
verilog/write_return.sv
verilog/read_route.sv
verilog/lite_demux.sv
bench/lite_demux_tb.sv

// ==== Bender.yml ====
package:
  name: lite_demux

sources:
  - verilog/lite_demux_pkg.sv
  - verilog/select_fifo.sv
  - verilog/aw_dispatch.sv
  - verilog/write_return.sv
  - verilog/read_route.sv
  - verilog/lite_demux.sv
  - target: test
    files:
      - bench/lite_demux_tb.sv
